// File: hdl/eg_cfg_pkg.sv
`default_nettype none

package eg_cfg_pkg;

    localparam int NUM_OPS    = 8;      // operators per sweep
    localparam int OP_W       = 3;      // operator index
    localparam int ENV_W      = 9;      // level and attenuation
    localparam int SILENCE    = 511;    // quietest level

    localparam int RATE_W     = 4;      // ar, dr, sl, rr fields
    localparam int TL_W       = 7;      // total level
    localparam int KSL_W      = 2;      // key-scale level
    localparam int BLOCK_W    = 3;      // octave block

    localparam int CNT_W      = 13;     // sweep counter

    localparam int FIFO_DEPTH = 4;      // output queue entries
    localparam int PIPE_LAT   = 3;      // slot issue to result push

endpackage

`default_nettype wire

// File: hdl/eg_types_pkg.sv
`default_nettype none

package eg_types_pkg;
    import eg_cfg_pkg::*;

    // held in the state memory, so width and codes are fixed
    typedef enum logic [3:0] {
        ATTACK  = 4'b0001,
        DECAY   = 4'b0010,
        SUSTAIN = 4'b0100,
        RELEASE = 4'b1000
    } env_state_t;

    typedef struct packed {
        logic [RATE_W-1:0]  ar;     // attack rate
        logic [RATE_W-1:0]  dr;     // decay rate
        logic [RATE_W-1:0]  sl;     // sustain level
        logic [RATE_W-1:0]  rr;     // release rate
        logic [TL_W-1:0]    tl;     // total level
        logic               ksr;    // key scale rate
        logic [KSL_W-1:0]   ksl;    // key scale level
        logic               egt;    // hold at sustain
        logic [BLOCK_W-1:0] block;
        logic               key_on;
    } op_params_t;

    typedef struct packed {
        logic [OP_W-1:0] op_num;
        op_params_t      params;
    } cfg_write_t;

    // one operator's work item through the pipeline
    typedef struct packed {
        logic [OP_W-1:0] op_num;
        op_params_t      params;
    } slot_t;

    typedef struct packed {
        logic [OP_W-1:0]  op_num;
        logic [ENV_W-1:0] atten;
    } env_out_t;

endpackage

`default_nettype wire

// File: hdl/op_param_file.sv
`timescale 1ns/1ps
`default_nettype none

module op_param_file
    import eg_cfg_pkg::*;
    import eg_types_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              busy,
    input  wire cfg_write_t  cfg,
    input  wire              cfg_valid,
    input  wire [OP_W-1:0]   rd_op,
    output logic             cfg_ready,
    output op_params_t       rd_params
);

    op_params_t regs [NUM_OPS];

    assign cfg_ready = !busy;           // no writes during a sweep
    assign rd_params = regs[rd_op];     // combinational read for the scheduler

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                regs[i] <= '0;
            end
        end else if (cfg_valid && cfg_ready) begin
            regs[cfg.op_num] <= cfg.params;
        end
    end

    // a write held off by a running sweep must stay pending and unchanged
    a_cfg_hold: assert property (
        @(posedge clk) disable iff (rst)
        cfg_valid && busy |=> cfg_valid && $stable(cfg)
    ) else $error("config write dropped or changed while sweep busy");

endmodule

`default_nettype wire

// File: hdl/slot_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module slot_scheduler
    import eg_cfg_pkg::*;
    import eg_types_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              sample_tick,
    input  wire [2:0]        fifo_free,
    input  wire op_params_t  params,
    output logic [OP_W-1:0]  rd_op,
    output logic             busy,
    output slot_t            slot,
    output logic             slot_valid,
    output logic             sweep_done
);

    logic [OP_W-1:0]     op_idx;
    logic [PIPE_LAT-1:0] vld_hist;      // slot_valid delayed 1..PIPE_LAT cycles
    logic [2:0]          in_flight;
    logic                issue;

    assign rd_op = op_idx;

    // slots not yet reflected in fifo_free
    always_comb begin
        in_flight = 3'(slot_valid);
        for (int i = 0; i < PIPE_LAT; i++) begin
            in_flight = in_flight + 3'(vld_hist[i]);
        end
        issue = busy && (fifo_free > in_flight);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_idx     <= '0;
            busy       <= 1'b0;
            slot_valid <= 1'b0;
            vld_hist   <= '0;
            sweep_done <= 1'b0;
        end else begin
            slot_valid <= issue;
            vld_hist   <= {vld_hist[PIPE_LAT-2:0], slot_valid};
            // one cycle after the last slot, lines up with its rate stage
            sweep_done <= slot_valid && (slot.op_num == OP_W'(NUM_OPS - 1));
            if (issue) begin
                op_idx <= op_idx + 1'b1;
                if (op_idx == OP_W'(NUM_OPS - 1)) begin
                    busy <= 1'b0;       // last slot out
                end
            end else if (sample_tick && !busy) begin
                busy   <= 1'b1;
                op_idx <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            slot <= '{op_num: op_idx, params: params};
        end
    end

    a_tick_idle: assert property (
        @(posedge clk) disable iff (rst)
        sample_tick |-> !busy
    ) else $error("sample_tick while sweep busy, tick ignored");

endmodule

`default_nettype wire

// File: hdl/eg_rate_calc.sv
`timescale 1ns/1ps
`default_nettype none

module eg_rate_calc
    import eg_cfg_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                sweep_done,
    input  wire [RATE_W-1:0]   req_rate,
    input  wire                ksr,
    input  wire [BLOCK_W-1:0]  block,
    output logic [RATE_W-1:0]  rate_hi,
    output logic [2:0]         shift
);

    logic [CNT_W-1:0]  sweep_cnt;
    logic [RATE_W:0]   rate_sum;        // one extra bit before the cap
    logic [RATE_W-1:0] rate_eff;
    logic [CNT_W-1:0]  cnt_mask;
    logic [2:0]        shift_nxt;

    always_comb begin
        rate_sum = (RATE_W+1)'(req_rate) +
                   (ksr ? (RATE_W+1)'(block) : (RATE_W+1)'(block >> 2));
        rate_eff = rate_sum[RATE_W] ? '1 : rate_sum[RATE_W-1:0];
        cnt_mask = '0;
        if (req_rate == '0) begin
            rate_eff  = '0;
            shift_nxt = 3'd0;
        end else if (rate_eff >= RATE_W'(12)) begin
            shift_nxt = 3'(rate_eff - RATE_W'(11));     // 1..4
        end else begin
            // step once every 2^(12-rate) sweeps
            cnt_mask  = (CNT_W'(1) << (RATE_W'(12) - rate_eff)) - 1'b1;
            shift_nxt = ((sweep_cnt & cnt_mask) == '0) ? 3'd1 : 3'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_cnt <= '0;
        end else if (sweep_done) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        rate_hi <= rate_eff;
        shift   <= shift_nxt;
    end

endmodule

`default_nettype wire

// File: hdl/envelope_generator.sv
`timescale 1ns/1ps
`default_nettype none

module envelope_generator
    import eg_cfg_pkg::*;
    import eg_types_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire slot_t  slot,
    input  wire         slot_valid,
    input  wire         sweep_done,
    output env_out_t    res,
    output logic        res_valid
);

    env_state_t       state_mem [NUM_OPS];
    logic [ENV_W-1:0] level_mem [NUM_OPS];

    // p0
    env_state_t        state_rd;
    logic [ENV_W-1:0]  level_rd;
    logic              eg_reset_p0;
    logic [RATE_W-1:0] req_rate_p0;

    // p1
    logic              valid_p1;
    slot_t             slot_p1;
    env_state_t        state_p1;
    logic [ENV_W-1:0]  level_p1;
    logic              eg_reset_p1;
    logic [RATE_W-1:0] req_rate_p1;

    // p2
    logic              valid_p2;
    slot_t             slot_p2;
    env_state_t        state_p2;
    logic [ENV_W-1:0]  level_p2;
    logic              eg_reset_p2;
    logic [RATE_W-1:0] rate_hi_p2;
    logic [2:0]        shift_p2;
    env_state_t        next_state;
    logic [ENV_W-1:0]  level_pre;
    logic [ENV_W-1:0]  inc;
    logic [ENV_W-1:0]  dec;
    logic [ENV_W:0]    level_sum;
    logic [ENV_W-1:0]  level_nxt;
    logic              env_off;
    logic [BLOCK_W+2:0] ksl_add;
    logic [ENV_W+1:0]  atten_sum;       // level + tl*4 + ksl peaks near 1075
    logic [ENV_W-1:0]  atten_nxt;

    // p3
    logic              valid_p3;
    logic [OP_W-1:0]   op_p3;
    env_state_t        state_p3;
    logic [ENV_W-1:0]  level_p3;
    logic [ENV_W-1:0]  atten_p3;

    always_comb begin
        state_rd    = state_mem[slot.op_num];
        level_rd    = level_mem[slot.op_num];
        eg_reset_p0 = slot.params.key_on && (state_rd == RELEASE);
        if (eg_reset_p0) begin
            req_rate_p0 = slot.params.ar;   // key-on restarts the envelope
        end else begin
            case (state_rd)
                ATTACK:  req_rate_p0 = slot.params.ar;
                DECAY:   req_rate_p0 = slot.params.dr;
                SUSTAIN: req_rate_p0 = slot.params.egt ? '0 : slot.params.rr;
                default: req_rate_p0 = slot.params.rr;
            endcase
        end
    end

    eg_rate_calc rate_i (
        .clk        (clk),
        .rst        (rst),
        .sweep_done (sweep_done),
        .req_rate   (req_rate_p1),
        .ksr        (slot_p1.params.ksr),
        .block      (slot_p1.params.block),
        .rate_hi    (rate_hi_p2),
        .shift      (shift_p2)
    );

    always_comb begin
        level_pre  = level_p2;
        next_state = state_p2;
        env_off    = (level_p2[ENV_W-1:3] == '1);   // 504 and up
        inc        = '0;
        dec        = '0;

        if (eg_reset_p2 && rate_hi_p2 == '1) begin
            level_pre = '0;                 // instant attack
        end
        if (state_p2 != ATTACK && !eg_reset_p2 && env_off) begin
            level_pre = ENV_W'(SILENCE);
        end

        case (state_p2)
            ATTACK: begin
                if (level_p2 == '0) begin
                    next_state = DECAY;
                end else if (slot_p2.params.key_on && shift_p2 != '0 && rate_hi_p2 != '1) begin
                    dec = (level_p2 >> (3'd4 - shift_p2)) + 1'b1;
                end
            end
            DECAY: begin
                if (level_p2[ENV_W-1 -: RATE_W] == slot_p2.params.sl) begin
                    next_state = SUSTAIN;
                end else if (shift_p2 != '0) begin
                    inc = ENV_W'(1) << (shift_p2 - 1'b1);
                end
            end
            default: begin                  // sustain and release
                if (shift_p2 != '0) begin
                    inc = ENV_W'(1) << (shift_p2 - 1'b1);
                end
            end
        endcase

        if (eg_reset_p2) begin
            next_state = ATTACK;
        end
        if (!slot_p2.params.key_on) begin
            next_state = RELEASE;
        end

        level_sum = {1'b0, level_pre} + {1'b0, inc};
        if (dec != '0) begin
            level_nxt = (level_pre > dec) ? level_pre - dec : '0;
        end else begin
            level_nxt = level_sum[ENV_W] ? ENV_W'(SILENCE) : level_sum[ENV_W-1:0];
        end

        ksl_add   = (slot_p2.params.ksl == '0) ? '0 :
                    {slot_p2.params.block, 3'b000} >> (2'd3 - slot_p2.params.ksl);
        atten_sum = (ENV_W+2)'(level_nxt) + (ENV_W+2)'({slot_p2.params.tl, 2'b00}) +
                    (ENV_W+2)'(ksl_add);
        atten_nxt = (atten_sum[ENV_W+1:ENV_W] != '0) ? ENV_W'(SILENCE) : atten_sum[ENV_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_p1 <= 1'b0;
            valid_p2 <= 1'b0;
            valid_p3 <= 1'b0;
        end else begin
            valid_p1 <= slot_valid;
            valid_p2 <= valid_p1;
            valid_p3 <= valid_p2;
        end
    end

    always_ff @(posedge clk) begin
        slot_p1     <= slot;
        state_p1    <= state_rd;
        level_p1    <= level_rd;
        eg_reset_p1 <= eg_reset_p0;
        req_rate_p1 <= req_rate_p0;

        slot_p2     <= slot_p1;
        state_p2    <= state_p1;
        level_p2    <= level_p1;
        eg_reset_p2 <= eg_reset_p1;

        op_p3       <= slot_p2.op_num;
        state_p3    <= next_state;
        level_p3    <= level_nxt;
        atten_p3    <= atten_nxt;
    end

    // reset leaves every operator silent in release
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_OPS; i++) begin
                state_mem[i] <= RELEASE;
                level_mem[i] <= ENV_W'(SILENCE);
            end
        end else if (valid_p3) begin
            state_mem[op_p3] <= state_p3;
            level_mem[op_p3] <= level_p3;
        end
    end

    assign res       = '{op_num: op_p3, atten: atten_p3};
    assign res_valid = valid_p3;

    // stored state from an earlier sweep must still be a legal code
    a_state_onehot: assert property (
        @(posedge clk) disable iff (rst)
        slot_valid |-> $onehot(state_rd)
    ) else $error("envelope state not one-hot");

endmodule

`default_nettype wire

// File: hdl/env_out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module env_out_fifo
    import eg_cfg_pkg::*;
    import eg_types_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire env_out_t  in,
    input  wire            in_valid,
    input  wire            out_ready,
    output env_out_t       out,
    output logic           out_valid,
    output logic [2:0]     free
);

    env_out_t                       mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]  rd_ptr;
    logic [2:0]                     count;
    logic                           push;
    logic                           pop;

    assign push      = in_valid && (count != 3'(FIFO_DEPTH));
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out       = mem[rd_ptr];
    assign free      = 3'(FIFO_DEPTH) - count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;      // wraps, depth is a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + 3'(push) - 3'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in;
        end
    end

    // scheduler credit must keep the pipeline from overrunning the queue
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> free != '0
    ) else $error("result pushed into full output FIFO");

endmodule

`default_nettype wire

// File: hdl/eg_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module eg_subsystem_top
    import eg_cfg_pkg::*;
    import eg_types_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              sample_tick,
    input  wire cfg_write_t  cfg,
    input  wire              cfg_valid,
    output logic             cfg_ready,
    output env_out_t         out,
    output logic             out_valid,
    input  wire              out_ready
);

    logic            busy;
    logic [OP_W-1:0] rd_op;
    op_params_t      rd_params;
    slot_t           slot;
    logic            slot_valid;
    logic            sweep_done;
    env_out_t        res;
    logic            res_valid;
    logic [2:0]      fifo_free;

    op_param_file param_file_i (
        .clk       (clk),
        .rst       (rst),
        .busy      (busy),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .rd_op     (rd_op),
        .cfg_ready (cfg_ready),
        .rd_params (rd_params)
    );

    slot_scheduler sched_i (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .fifo_free   (fifo_free),
        .params      (rd_params),
        .rd_op       (rd_op),
        .busy        (busy),
        .slot        (slot),
        .slot_valid  (slot_valid),
        .sweep_done  (sweep_done)
    );

    envelope_generator eg_i (
        .clk        (clk),
        .rst        (rst),
        .slot       (slot),
        .slot_valid (slot_valid),
        .sweep_done (sweep_done),
        .res        (res),
        .res_valid  (res_valid)
    );

    env_out_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in        (res),
        .in_valid  (res_valid),
        .out_ready (out_ready),
        .out       (out),
        .out_valid (out_valid),
        .free      (fifo_free)
    );

endmodule

`default_nettype wire

// File: bench/tb_eg_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eg_subsystem
    import eg_cfg_pkg::*;
    import eg_types_pkg::*;
();

    localparam int IDLE_TIMEOUT  = 100;     // cycles to wait for an idle scheduler
    localparam int SWEEP_TIMEOUT = 400;     // cycles to wait for one sweep's results
    localparam int EXP_DEPTH     = 2048;

    logic       clk;
    logic       rst;
    logic       sample_tick;
    cfg_write_t cfg;
    logic       cfg_valid;
    logic       cfg_ready;
    env_out_t   out_data;
    logic       out_valid;
    logic       out_ready;

    integer     seed;
    string      test_name;
    int         errors;
    int         checks;
    int         cmp_errors;
    int         cmp_checks;
    int         sent_count;
    int         got_count;
    logic       bp_on;                      // random out_ready while waiting

    env_out_t   exp_mem [EXP_DEPTH];        // expected results in issue order
    op_params_t shadow  [NUM_OPS];          // parameters as last written
    env_state_t m_state [NUM_OPS];
    int         m_level [NUM_OPS];
    int         m_cnt;

    eg_subsystem_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .sample_tick (sample_tick),
        .cfg         (cfg),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .out         (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    always #4 clk = ~clk;

    // reference envelope step for one operator
    function automatic env_out_t model_step(input int op, input op_params_t p);
        env_state_t st;
        env_state_t nst;
        logic       eg_reset;
        int         lvl;
        int         new_lvl;
        int         req;
        int         rate;
        int         shift;
        int         inc;
        int         dec;
        int         ksl_add;
        int         atten;
        env_out_t   r;
        st       = m_state[op];
        lvl      = m_level[op];
        eg_reset = p.key_on && (st == RELEASE);
        if (eg_reset || st == ATTACK) req = int'(p.ar);
        else if (st == DECAY) req = int'(p.dr);
        else if (st == SUSTAIN) req = p.egt ? 0 : int'(p.rr);
        else req = int'(p.rr);

        rate  = 0;
        shift = 0;
        if (req != 0) begin
            rate = req + (p.ksr ? int'(p.block) : int'(p.block) / 4);
            if (rate > 15) rate = 15;
            if (rate >= 12) shift = rate - 11;
            else if ((m_cnt & ((1 << (12 - rate)) - 1)) == 0) shift = 1;
        end

        new_lvl = lvl;
        if (eg_reset && rate == 15) new_lvl = 0;               // instant attack
        if (st != ATTACK && !eg_reset && lvl >= 504) new_lvl = SILENCE;

        nst = st;
        inc = 0;
        dec = 0;
        if (st == ATTACK) begin
            if (lvl == 0) nst = DECAY;
            else if (p.key_on && shift > 0 && rate < 15) dec = (lvl >> (4 - shift)) + 1;
        end else if (st == DECAY && lvl / 32 == int'(p.sl)) begin
            nst = SUSTAIN;
        end else if (shift > 0) begin
            inc = 1 << (shift - 1);
        end
        if (eg_reset) nst = ATTACK;
        if (!p.key_on) nst = RELEASE;

        if (dec > 0) new_lvl = (new_lvl > dec) ? new_lvl - dec : 0;
        else new_lvl = (new_lvl + inc > SILENCE) ? SILENCE : new_lvl + inc;

        ksl_add = (p.ksl == 0) ? 0 : (int'(p.block) * 8) >> (3 - int'(p.ksl));
        atten   = new_lvl + int'(p.tl) * 4 + ksl_add;
        if (atten > SILENCE) atten = SILENCE;

        m_state[op] = nst;
        m_level[op] = new_lvl;
        if (op == NUM_OPS - 1) m_cnt++;                         // end of sweep
        r.op_num = 3'(op);
        r.atten  = 9'(atten);
        return r;
    endfunction

    function automatic op_params_t params_of(input int ar, dr, sl, rr, tl, ksr, ksl, egt,
                                             block, key_on);
        params_of = '{ar: 4'(ar), dr: 4'(dr), sl: 4'(sl), rr: 4'(rr), tl: 7'(tl),
                      ksr: 1'(ksr), ksl: 2'(ksl), egt: 1'(egt), block: 3'(block),
                      key_on: 1'(key_on)};
    endfunction

    // every output transfer against the next expected result
    always @(posedge clk) begin : compare_outputs
        env_out_t want;
        if (!rst && out_valid && out_ready) begin
            cmp_checks++;
            if (got_count >= sent_count) begin
                cmp_errors++;
                $display("output op %0d atten %0d arrived with no result expected",
                         out_data.op_num, out_data.atten);
            end else begin
                want = exp_mem[got_count];
                if (out_data !== want) begin
                    cmp_errors++;
                    $display("Mismatch %s: expected op %0d atten %0d, actual op %0d atten %0d",
                             test_name, want.op_num, want.atten, out_data.op_num,
                             out_data.atten);
                end
            end
            got_count++;
        end
    end

    task automatic write_cfg(input int op, input op_params_t p);
        int cycles;
        cycles     = 0;
        shadow[op] = p;
        while (!cfg_ready && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cfg_ready) begin
            errors++;
            $display("timeout: cfg_ready stayed low, write to op %0d not done", op);
        end else begin
            cfg       = '{op_num: 3'(op), params: p};
            cfg_valid = 1'b1;
            @(negedge clk);
            cfg_valid = 1'b0;
        end
    endtask

    task automatic rewrite_random_op();
        logic [63:0] r;
        op_params_t  p;
        r[63:32] = $random(seed);
        r[31:0]  = $random(seed);
        p        = r[$bits(op_params_t)-1:0];
        p.key_on = (r[41:40] != 2'b00);     // mostly keyed on
        write_cfg(int'(r[63:61]), p);
    endtask

    // expected results are queued before the tick
    task automatic run_sweep();
        int cycles;
        int op;
        cycles = 0;
        while (!cfg_ready && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cfg_ready) begin
            errors++;
            $display("timeout: scheduler still busy before tick in test %s", test_name);
        end
        for (op = 0; op < NUM_OPS; op++) begin
            exp_mem[sent_count] = model_step(op, shadow[op]);
            sent_count++;
        end
        sample_tick = 1'b1;
        @(negedge clk);
        sample_tick = 1'b0;
        cycles = 0;
        while (got_count < sent_count && cycles < SWEEP_TIMEOUT) begin
            @(negedge clk);
            out_ready = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
            cycles++;
        end
        out_ready = 1'b1;
        if (got_count < sent_count) begin
            errors++;
            $display("timeout: %0d of %0d results received in test %s",
                     got_count, sent_count, test_name);
        end
    endtask

    initial begin
        int i;
        int j;
        int tl_v;
        int ksl_v;
        int blk_v;
        clk         = 1'b0;
        rst         = 1'b1;
        sample_tick = 1'b0;
        cfg         = '0;
        cfg_valid   = 1'b0;
        out_ready   = 1'b1;
        seed        = 32'h1329_b82c;
        errors      = 0;
        checks      = 0;
        cmp_errors  = 0;
        cmp_checks  = 0;
        sent_count  = 0;
        got_count   = 0;
        bp_on       = 1'b0;
        m_cnt       = 0;
        test_name   = "reset";
        for (i = 0; i < NUM_OPS; i++) begin
            shadow[i]  = '0;
            m_state[i] = RELEASE;
            m_level[i] = SILENCE;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        checks += 2;
        if (out_valid !== 1'b0) begin
            errors++;
            $display("out_valid high after reset");
        end
        if (cfg_ready !== 1'b1) begin
            errors++;
            $display("cfg_ready low after reset");
        end
        run_sweep();                            // all operators silent at atten 511

        test_name = "attack_decay";
        write_cfg(0, params_of(15, 0, 0, 0, 0, 1, 0, 1, 7, 1));
        write_cfg(1, params_of(13, 15, 2, 0, 0, 0, 0, 1, 7, 1));
        repeat (24) run_sweep();

        test_name = "key_off";
        write_cfg(0, params_of(15, 0, 0, 15, 0, 1, 0, 0, 7, 0));
        write_cfg(1, params_of(13, 15, 2, 15, 0, 1, 0, 0, 7, 0));
        for (i = 0; i < 80 && (m_level[0] != SILENCE || m_level[1] != SILENCE); i++) begin
            run_sweep();
        end

        test_name = "atten";
        for (i = 0; i < 6; i++) begin
            for (j = 0; j < NUM_OPS - 1; j++) begin
                tl_v  = $unsigned($random(seed)) % 128;
                ksl_v = $unsigned($random(seed)) % 4;
                blk_v = $unsigned($random(seed)) % 8;
                write_cfg(j, params_of(15, 0, 0, 15, tl_v, 1, ksl_v, 1, blk_v, 1));
            end
            write_cfg(7, params_of(15, 0, 0, 15, 127, 1, 3, 1, 7, 1));     // overflows
            run_sweep();
        end

        test_name = "backpressure";
        bp_on     = 1'b1;
        for (i = 0; i < 30; i++) begin
            repeat (3) rewrite_random_op();
            run_sweep();
        end
        bp_on = 1'b0;

        repeat (20) @(negedge clk);             // catch late or extra outputs
        checks++;
        if (got_count != sent_count) begin
            errors++;
            $display("%0d results expected, %0d received", sent_count, got_count);
        end
        errors = errors + cmp_errors;
        checks = checks + cmp_checks;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/eg_cfg_pkg.sv
hdl/eg_types_pkg.sv
hdl/op_param_file.sv
hdl/slot_scheduler.sv
hdl/eg_rate_calc.sv
hdl/envelope_generator.sv
hdl/env_out_fifo.sv
hdl/eg_subsystem_top.sv
bench/tb_eg_subsystem.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_eg_subsystem
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --assert -Mdir $(BUILD_DIR)
FAIL_MSG   := FAIL: see errors above

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
